/* sim.f */
+incdir+include
logic/lc3b_types.sv
logic/control_rom.sv
logic/lc3b_alu.sv
logic/leapfrog_logic.sv
logic/execute.sv
logic/ex_mem_latch.sv
logic/execute_unit.sv
test/execute_unit_chk.sv
test/tb_execute_unit.sv

/* run.sh */
#!/usr/bin/env bash
# builds the execute unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_execute_unit \
    --Mdir obj_dir \
    -f sim.f

./obj_dir/Vtb_execute_unit

/* test/tb_execute_unit.sv */
`default_nettype none
`include "lc3b_cfg.svh"

module tb_execute_unit import lc3b_types::*;
();

    localparam int num_cycles = 2000;
    localparam int idle_limit = 20;

    logic             clk;
    logic             arst_n;
    lc3b_word         ir;
    lc3b_word         npc;
    lc3b_word         sr1;
    lc3b_word         sr2;
    lc3b_reg          sr1_reg;
    lc3b_reg          sr2_reg;
    lc3b_nzp          cc;
    lc3b_reg          dr_in;
    logic             valid_in;
    lc3b_opcode       next_opcode;
    logic             mem_stall;
    logic             mem_valid;
    lc3b_control_word mem_cw;
    lc3b_word         mem_address;
    lc3b_word         mem_result;
    lc3b_reg          mem_dr;
    lc3b_word         mem_npc;
    logic             lf_valid;
    lc3b_reg          lf_dr;
    lc3b_word         lf_result;
    logic             ex_load_cc;
    logic             ex_load_regfile;
    logic             execute_br_stall;
    logic             execute_indirect_stall;
    logic             stall;

    // expected contents of the latch and the retire slot
    logic             m_valid;
    lc3b_control_word m_cw;
    lc3b_word         m_address;
    lc3b_word         m_result;
    lc3b_word         m_npc;
    lc3b_reg          m_dr;
    logic             m_lf_valid;
    lc3b_reg          m_lf_dr;
    lc3b_word         m_lf_result;
    logic             hold;

    // ldi and sti last, so next_opcode can skip them
    lc3b_opcode issue_ops [12] = '{op_add, op_and, op_not, op_shf, op_br, op_jmp,
                                   op_lea, op_ldr, op_str, op_ldi, op_sti, op_trap};

    execute_unit execute_unit_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic lc3b_control_word rom_model(input lc3b_word ins);
        lc3b_control_word c;
        lc3b_opcode       op;
        logic             alu_op;
        logic             mem_op;
        logic             imm;
        op = lc3b_opcode'(ins[15:12]);
        alu_op = op inside {op_add, op_and, op_not, op_shf};
        mem_op = op inside {op_ldr, op_str, op_ldi, op_sti};
        imm = ins[5];
        c = '0;
        c.opcode = op;
        case (op)
            op_add:  c.aluop = alu_add;
            op_and:  c.aluop = alu_and;
            op_not:  c.aluop = alu_not;
            op_shf:  c.aluop = !ins[4] ? alu_sll : (ins[5] ? alu_sra : alu_srl);
            default: c.aluop = alu_pass;
        endcase
        c.load_cc        = alu_op || (op inside {op_ldr, op_ldi});
        c.load_regfile   = alu_op || (op inside {op_lea, op_ldr, op_ldi, op_trap});
        c.branch_stall   = op inside {op_br, op_jmp, op_trap};
        c.mem_read       = op inside {op_ldr, op_ldi, op_sti, op_trap};
        c.mem_write      = (op == op_str);
        c.sr1_needed     = alu_op || mem_op || (op == op_jmp);
        c.sr2_needed     = ((op inside {op_add, op_and}) && !imm) || (op inside {op_str, op_sti});
        c.lshf_enable    = mem_op || (op inside {op_br, op_lea});
        c.sr2mux_sel     = (op == op_shf) ? 2'd2 :
                           (((op inside {op_add, op_and}) && imm) ? 2'd1 : 2'd0);
        c.addr1mux_sel   = mem_op || (op == op_jmp);
        c.addr2mux_sel   = mem_op ? 2'd1 : ((op inside {op_br, op_lea}) ? 2'd2 : 2'd0);
        c.memaddrmux_sel = (op == op_trap);
        return c;
    endfunction

    // second access of an indirect pair replaces the issued word
    function automatic lc3b_control_word issue_cw_model(input lc3b_control_word c,
                                                        input lc3b_opcode nxt);
        lc3b_control_word t;
        if (nxt != op_ldi && nxt != op_sti)
            return c;
        t = '0;
        t.opcode = (nxt == op_ldi) ? op_ldr : op_str;
        t.aluop = alu_pass;
        t.sr1_needed = 1'b1;
        t.addr1mux_sel = 1'b1;
        if (nxt == op_ldi)
        begin
            t.mem_read = 1'b1;
            t.load_cc = 1'b1;
            t.load_regfile = 1'b1;
        end
        else
        begin
            t.mem_write = 1'b1;
            t.sr2_needed = 1'b1;
        end
        return t;
    endfunction

    function automatic lc3b_word address_model(input lc3b_word ins, input lc3b_word npc_v,
                                                input lc3b_word sr1_v);
        case (lc3b_opcode'(ins[15:12]))
            op_trap:                        return lc3b_word'(ins[7:0]) << 1;
            op_ldr, op_str, op_ldi, op_sti: return sr1_v + (lc3b_word'($signed(ins[5:0])) << 1);
            op_br, op_lea:                  return npc_v + (lc3b_word'($signed(ins[8:0])) << 1);
            op_jmp:                         return sr1_v;
            default:                        return npc_v;
        endcase
    endfunction

    function automatic lc3b_word result_model(input lc3b_word ins, input lc3b_word sr1_v,
                                              input lc3b_word sr2_v, input lc3b_word addr);
        lc3b_word   b;
        lc3b_word   fill;
        logic [3:0] sh;
        b = ins[5] ? lc3b_word'($signed(ins[4:0])) : sr2_v;
        sh = ins[3:0];
        fill = sr1_v[`LC3B_WORD_W-1] ? ~({`LC3B_WORD_W{1'b1}} >> sh) : '0; // sign bits shifted in
        case (lc3b_opcode'(ins[15:12]))
            op_add:  return sr1_v + b;
            op_and:  return sr1_v & b;
            op_not:  return ~sr1_v;
            op_shf:
            begin
                if (!ins[4])
                    return sr1_v << sh;
                else if (!ins[5])
                    return sr1_v >> sh;
                else
                    return (sr1_v >> sh) | fill;
            end
            op_lea:  return addr;
            default: return sr1_v;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] rnd;
        int          idx;
        if (!hold) // a stalled instruction stays on the inputs
        begin
            idx = int'($urandom % 12);
            rnd = $urandom;
            ir = {issue_ops[idx], rnd[11:0]};
            rnd = $urandom;
            sr1 = rnd[15:0];
            sr2 = rnd[31:16];
            rnd = $urandom;
            npc = rnd[15:0];
            sr1_reg = rnd[18:16];
            sr2_reg = rnd[21:19];
            dr_in = rnd[24:22];
            cc = rnd[27:25];
            valid_in = (rnd[31:28] != 4'd0);
        end
        rnd = $urandom;
        mem_stall = (rnd[1:0] == 2'd0);
        if (rnd[4:2] == 3'd0)
            next_opcode = rnd[5] ? op_ldi : op_sti;
        else
            next_opcode = issue_ops[int'(rnd[15:8]) % 9];
    endtask

    task automatic check_and_advance();
        lc3b_control_word rom_c;
        lc3b_control_word ex_c;
        lc3b_word         addr_e;
        lc3b_word         res_e;
        logic             mem_load_m;
        logic             hazard;
        logic             blocked;
        logic             lf_load_e;
        logic             indirect_e;
        logic             stall_e;
        rom_c = rom_model(ir);
        ex_c = issue_cw_model(rom_c, next_opcode);
        addr_e = address_model(ir, npc, sr1);
        res_e = result_model(ir, sr1, sr2, addr_e);
        mem_load_m = m_valid & m_cw.mem_read;
        hazard = ex_c.load_cc | (ex_c.sr1_needed & (sr1_reg == m_dr)) |
                 (ex_c.sr2_needed & (sr2_reg == m_dr));
        blocked = ex_c.mem_read | ex_c.mem_write | ~ex_c.load_regfile | (mem_load_m & hazard);
        lf_load_e = mem_stall & valid_in & ~blocked;
        indirect_e = (next_opcode == op_ldi) || (next_opcode == op_sti);
        stall_e = (mem_stall & valid_in & blocked) | indirect_e;
        check_value(32'(ex_load_cc), 32'(valid_in & rom_c.load_cc), "ex_load_cc");
        check_value(32'(ex_load_regfile), 32'(valid_in & rom_c.load_regfile), "ex_load_regfile");
        check_value(32'(execute_br_stall), 32'(valid_in & rom_c.branch_stall), "execute_br_stall");
        check_value(32'(execute_indirect_stall), 32'(indirect_e), "execute_indirect_stall");
        check_value(32'(stall), 32'(stall_e), "stall");
        m_lf_valid = lf_load_e;
        if (lf_load_e)
        begin
            m_lf_dr = dr_in;
            m_lf_result = res_e;
        end
        if (!mem_stall)
        begin
            m_valid = valid_in;
            m_cw = ex_c;
            m_address = addr_e;
            m_result = res_e;
            m_npc = npc;
            m_dr = dr_in;
        end
        hold = stall_e;
    endtask

    task automatic check_latched();
        check_value(32'(mem_valid), 32'(m_valid), "mem_valid");
        check_value(32'(mem_cw), 32'(m_cw), "mem_cw");
        if (m_valid)
        begin
            check_value(32'(mem_address), 32'(m_address), "mem_address");
            check_value(32'(mem_result), 32'(m_result), "mem_result");
            check_value(32'(mem_npc), 32'(m_npc), "mem_npc");
            check_value(32'(mem_dr), 32'(m_dr), "mem_dr");
        end
        check_value(32'(lf_valid), 32'(m_lf_valid), "lf_valid");
        if (m_lf_valid)
        begin
            check_value(32'(lf_dr), 32'(m_lf_dr), "lf_dr");
            check_value(32'(lf_result), 32'(m_lf_result), "lf_result");
        end
    endtask

    // run bubbles through until nothing is left in flight
    task automatic wait_idle();
        int n;
        n = 0;
        do
        begin
            #10;
            check_and_advance();
            @(negedge clk);
            check_latched();
            n++;
        end
        while ((stall !== 1'b0 || mem_valid !== 1'b0 || lf_valid !== 1'b0) && n < idle_limit);
        if (stall !== 1'b0 || mem_valid !== 1'b0 || lf_valid !== 1'b0)
        begin
            $display("Timeout: the execute unit did not drain after the stimulus ended");
            $display("Simulation failed");
            $fatal(1, "drain timeout");
        end
    endtask

    initial
    begin
        void'($urandom(32'hc9ce));
        arst_n = 1'b0;
        ir = '0;
        npc = '0;
        sr1 = '0;
        sr2 = '0;
        sr1_reg = '0;
        sr2_reg = '0;
        cc = '0;
        dr_in = '0;
        valid_in = 1'b0;
        next_opcode = op_add;
        mem_stall = 1'b0;
        // payload flops load the zero inputs while reset is held
        m_valid = 1'b0;
        m_cw = '0;
        m_address = '0;
        m_result = '0;
        m_npc = '0;
        m_dr = '0;
        m_lf_valid = 1'b0;
        m_lf_dr = '0;
        m_lf_result = '0;
        hold = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_latched();
        for (int i = 0; i < num_cycles; i++)
        begin
            drive_inputs();
            #10;
            check_and_advance();
            @(negedge clk);
            check_latched();
        end
        mem_stall = 1'b0;
        valid_in = 1'b0;
        next_opcode = op_add;
        wait_idle();
        $display("Simulation passed");
        $finish;
    end

endmodule : tb_execute_unit

`default_nettype wire

/* test/execute_unit_chk.sv */
`default_nettype none

module execute_unit_chk import lc3b_types::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             mem_stall,
    input  logic             leapfrog_load,
    input  logic             mem_valid,
    input  lc3b_control_word mem_cw,
    input  lc3b_word         mem_address,
    input  lc3b_word         mem_result,
    input  logic             lf_valid
);

    // back-pressure freezes the stage
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_stall |=> $stable(mem_valid) && $stable(mem_cw) &&
                      $stable(mem_address) && $stable(mem_result))
    else $error("ex/mem latch changed while mem_stall was high");

    // the retire slot only takes an instruction the main stage did not load
    assert property (@(posedge clk) disable iff (!arst_n) leapfrog_load |-> mem_stall)
    else $error("leapfrog capture while the ex/mem latch was loading");

    assert property (@(posedge clk) !arst_n |-> !mem_valid && !lf_valid &&
        !mem_cw.mem_read && !mem_cw.mem_write && !mem_cw.load_regfile && !mem_cw.load_cc)
    else $error("latch not cleared by reset");

endmodule : execute_unit_chk

bind ex_mem_latch execute_unit_chk latch_chk
(
    .clk(clk),
    .arst_n(arst_n),
    .mem_stall(mem_stall),
    .leapfrog_load(leapfrog_load),
    .mem_valid(mem_valid),
    .mem_cw(mem_cw),
    .mem_address(mem_address),
    .mem_result(mem_result),
    .lf_valid(lf_valid)
);

`default_nettype wire

/* logic/execute_unit.sv */
`default_nettype none

module execute_unit import lc3b_types::*;
(
    input  logic             clk,
    input  logic             arst_n,

    input  lc3b_word         ir,
    input  lc3b_word         npc,
    input  lc3b_word         sr1,
    input  lc3b_word         sr2,
    input  lc3b_reg          sr1_reg,
    input  lc3b_reg          sr2_reg,
    input  lc3b_nzp          cc,       // decode supplies it, no consumer in this stage
    input  lc3b_reg          dr_in,
    input  logic             valid_in,
    input  lc3b_opcode       next_opcode,

    input  logic             mem_stall,
    output logic             mem_valid,
    output lc3b_control_word mem_cw,
    output lc3b_word         mem_address,
    output lc3b_word         mem_result,
    output lc3b_reg          mem_dr,
    output lc3b_word         mem_npc,

    output logic             lf_valid,
    output lc3b_reg          lf_dr,
    output lc3b_word         lf_result,

    output logic             ex_load_cc,
    output logic             ex_load_regfile,
    output logic             execute_br_stall,
    output logic             execute_indirect_stall,
    output logic             stall
);

    lc3b_control_word rom_cw;
    lc3b_control_word ex_cw;
    lc3b_word         ex_address;
    lc3b_word         ex_result;
    logic             leapfrog_load;
    logic             leapfrog_stall;
    logic             mem_load;

    control_rom rom
    (
        .ir(ir),
        .cw(rom_cw)
    );

    execute ex
    (
        .npc_in(npc),
        .ir_in(ir),
        .sr1(sr1),
        .sr2(sr2),
        .cw_in(rom_cw),
        .valid_in(valid_in),
        .next_opcode(next_opcode),
        .address(ex_address),
        .result(ex_result),
        .cw(ex_cw),
        .ex_load_cc(ex_load_cc),
        .ex_load_regfile(ex_load_regfile),
        .execute_br_stall(execute_br_stall),
        .execute_indirect_stall(execute_indirect_stall)
    );

    leapfrog_logic lf
    (
        .mem_stall(mem_stall),
        .valid_in(valid_in),
        .cw(ex_cw),
        .mem_dr(mem_dr),
        .sr1_reg(sr1_reg),
        .sr2_reg(sr2_reg),
        .mem_load(mem_load),
        .leapfrog_load(leapfrog_load),
        .leapfrog_stall(leapfrog_stall)
    );

    ex_mem_latch latch
    (
        .clk(clk),
        .arst_n(arst_n),
        .mem_stall(mem_stall),
        .valid_in(valid_in),
        .leapfrog_load(leapfrog_load),
        .cw(ex_cw),
        .address(ex_address),
        .result(ex_result),
        .npc_in(npc),
        .dr_in(dr_in),
        .mem_valid(mem_valid),
        .mem_cw(mem_cw),
        .mem_address(mem_address),
        .mem_result(mem_result),
        .mem_npc(mem_npc),
        .mem_dr(mem_dr),
        .mem_load(mem_load),
        .lf_valid(lf_valid),
        .lf_dr(lf_dr),
        .lf_result(lf_result)
    );

    assign stall = (mem_stall & leapfrog_stall) | execute_indirect_stall;

endmodule : execute_unit

`default_nettype wire

/* logic/ex_mem_latch.sv */
`default_nettype none
`include "lc3b_cfg.svh"

module ex_mem_latch import lc3b_types::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             mem_stall,
    input  logic             valid_in,
    input  logic             leapfrog_load,
    input  lc3b_control_word cw,
    input  lc3b_word         address,
    input  lc3b_word         result,
    input  lc3b_word         npc_in,
    input  lc3b_reg          dr_in,
    output logic             mem_valid,
    output lc3b_control_word mem_cw,
    output lc3b_word         mem_address,
    output lc3b_word         mem_result,
    output lc3b_word         mem_npc,
    output lc3b_reg          mem_dr,
    output logic             mem_load,
    output logic             lf_valid,
    output lc3b_reg          lf_dr,
    output lc3b_word         lf_result
);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_valid <= 1'b0;
            mem_cw    <= '0;
        end
        else if (!mem_stall)
        begin
            mem_valid <= valid_in; // bubble when nothing issued
            mem_cw    <= cw;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!mem_stall)
        begin
            mem_address <= address;
            mem_result  <= result;
            mem_npc     <= npc_in;
            mem_dr      <= dr_in;
        end
    end

    // one entry retire slot, a pulse per capture
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            lf_valid <= 1'b0;
        else
            lf_valid <= leapfrog_load;
    end

    always_ff @(posedge clk)
    begin
        if (leapfrog_load)
        begin
            lf_dr     <= dr_in;
            lf_result <= result;
        end
    end

    assign mem_load = mem_valid & mem_cw.mem_read;

endmodule : ex_mem_latch

`default_nettype wire

/* logic/execute.sv */
`default_nettype none
`include "lc3b_cfg.svh"

module execute import lc3b_types::*;
(
    input  lc3b_word         npc_in,
    input  lc3b_word         ir_in,
    input  lc3b_word         sr1,
    input  lc3b_word         sr2,
    input  lc3b_control_word cw_in,
    input  logic             valid_in,
    input  lc3b_opcode       next_opcode,
    output lc3b_word         address,
    output lc3b_word         result,
    output lc3b_control_word cw,
    output logic             ex_load_cc,
    output logic             ex_load_regfile,
    output logic             execute_br_stall,
    output logic             execute_indirect_stall
);

    // second access of ldi/sti goes through the loaded pointer
    localparam lc3b_control_word ldr_template = '{
        opcode: op_ldr,
        aluop: alu_pass,
        load_cc: 1'b1,
        load_regfile: 1'b1,
        mem_read: 1'b1,
        sr1_needed: 1'b1,
        addr1mux_sel: 1'b1,
        default: '0
    };

    localparam lc3b_control_word str_template = '{
        opcode: op_str,
        aluop: alu_pass,
        mem_write: 1'b1,
        sr1_needed: 1'b1,
        sr2_needed: 1'b1,
        addr1mux_sel: 1'b1,
        default: '0
    };

    lc3b_word base;
    lc3b_word offset;
    lc3b_word offset_adj;
    lc3b_word trap_vector;
    lc3b_word operand;
    lc3b_word alu_out;

    assign base = cw_in.addr1mux_sel ? sr1 : npc_in;

    always_comb
    begin
        case (cw_in.addr2mux_sel)
            2'b00:   offset = '0;
            2'b01:   offset = {{(`LC3B_WORD_W-6){ir_in[5]}}, ir_in[5:0]};
            2'b10:   offset = {{(`LC3B_WORD_W-9){ir_in[8]}}, ir_in[8:0]};
            default: offset = {{(`LC3B_WORD_W-11){ir_in[10]}}, ir_in[10:0]};
        endcase
    end

    assign offset_adj = cw_in.lshf_enable ? {offset[`LC3B_WORD_W-2:0], 1'b0} : offset;

    // trapvect8 zero extended, word aligned
    assign trap_vector = {{(`LC3B_WORD_W-9){1'b0}}, ir_in[7:0], 1'b0};

    assign address = cw_in.memaddrmux_sel ? trap_vector : base + offset_adj;

    always_comb
    begin
        case (cw_in.sr2mux_sel)
            2'b00:   operand = sr2;
            2'b01:   operand = {{(`LC3B_WORD_W-5){ir_in[4]}}, ir_in[4:0]};
            2'b10:   operand = {{(`LC3B_WORD_W-4){1'b0}}, ir_in[3:0]}; // shift amount
            default: operand = '0;
        endcase
    end

    lc3b_alu alu
    (
        .aluop(cw_in.aluop),
        .a(sr1),
        .b(operand),
        .f(alu_out)
    );

    assign result = (cw_in.opcode == op_lea) ? address : alu_out; // lea writes the ea

    assign execute_indirect_stall = (next_opcode == op_ldi) || (next_opcode == op_sti);

    always_comb
    begin
        if (next_opcode == op_ldi)
            cw = ldr_template;
        else if (next_opcode == op_sti)
            cw = str_template;
        else
            cw = cw_in;
    end

    assign ex_load_cc       = valid_in & cw_in.load_cc;
    assign ex_load_regfile  = valid_in & cw_in.load_regfile;
    assign execute_br_stall = valid_in & cw_in.branch_stall;

endmodule : execute

`default_nettype wire

/* logic/leapfrog_logic.sv */
`default_nettype none
`include "lc3b_cfg.svh"

module leapfrog_logic import lc3b_types::*;
(
    input  logic             mem_stall,
    input  logic             valid_in,
    input  lc3b_control_word cw,
    input  lc3b_reg          mem_dr,
    input  lc3b_reg          sr1_reg,
    input  lc3b_reg          sr2_reg,
    input  logic             mem_load,
    output logic             leapfrog_load,
    output logic             leapfrog_stall
);

    logic mem_access;
    logic cc_hazard;
    logic src_hazard;
    logic blocked;

    assign mem_access = cw.mem_read | cw.mem_write;

    // the older load would set cc after us
    assign cc_hazard = cw.load_cc & mem_load;

    assign src_hazard = mem_load & ((cw.sr1_needed & (sr1_reg == mem_dr)) |
                                    (cw.sr2_needed & (sr2_reg == mem_dr)));

    // without a destination there is nothing to retire early
    assign blocked = mem_access | cc_hazard | src_hazard | ~cw.load_regfile;

    assign leapfrog_stall = mem_stall & valid_in & blocked;
    assign leapfrog_load  = mem_stall & valid_in & ~blocked;

endmodule : leapfrog_logic

`default_nettype wire

/* logic/lc3b_alu.sv */
`default_nettype none
`include "lc3b_cfg.svh"

module lc3b_alu import lc3b_types::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb
    begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            alu_sll: f = a << shamt;
            alu_srl: f = a >> shamt;
            alu_sra: f = lc3b_word'($signed(a) >>> shamt); // sign fill
            default: f = a;
        endcase
    end

endmodule : lc3b_alu

`default_nettype wire

/* logic/control_rom.sv */
`default_nettype none
`include "lc3b_cfg.svh"

module control_rom import lc3b_types::*;
(
    input  lc3b_word         ir,
    output lc3b_control_word cw
);

    lc3b_opcode opc;

    assign opc = lc3b_opcode'(ir[`LC3B_WORD_W-1 -: `LC3B_OPC_W]);

    always_comb
    begin
        cw = '0;
        cw.opcode = opc;
        cw.aluop = alu_pass;

        case (opc)
            op_add, op_and:
            begin
                cw.aluop = (opc == op_add) ? alu_add : alu_and;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr1_needed = 1'b1;
                cw.sr2_needed = ~ir[5];
                cw.sr2mux_sel = ir[5] ? 2'b01 : 2'b00; // imm5 form
            end
            op_not:
            begin
                cw.aluop = alu_not;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr1_needed = 1'b1;
            end
            op_shf:
            begin
                // ir[4] picks direction, ir[5] arithmetic right
                if (!ir[4])
                    cw.aluop = alu_sll;
                else
                    cw.aluop = ir[5] ? alu_sra : alu_srl;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr1_needed = 1'b1;
                cw.sr2mux_sel = 2'b10;
            end
            op_br, op_lea:
            begin
                cw.branch_stall = (opc == op_br);
                cw.load_regfile = (opc == op_lea);
                cw.addr2mux_sel = 2'b10;
                cw.lshf_enable = 1'b1;
            end
            op_jmp:
            begin
                cw.branch_stall = 1'b1;
                cw.sr1_needed = 1'b1;
                cw.addr1mux_sel = 1'b1;
            end
            op_ldr, op_ldi, op_str, op_sti:
            begin
                // ldi and sti read the pointer first
                cw.mem_read = (opc != op_str);
                cw.mem_write = (opc == op_str);
                cw.load_cc = (opc == op_ldr) || (opc == op_ldi);
                cw.load_regfile = (opc == op_ldr) || (opc == op_ldi);
                cw.sr1_needed = 1'b1;
                cw.sr2_needed = (opc == op_str) || (opc == op_sti); // store data
                cw.addr1mux_sel = 1'b1;
                cw.addr2mux_sel = 2'b01;
                cw.lshf_enable = 1'b1;
            end
            op_trap:
            begin
                cw.mem_read = 1'b1;     // vector table lookup
                cw.load_regfile = 1'b1; // r7 gets npc
                cw.branch_stall = 1'b1;
                cw.memaddrmux_sel = 1'b1;
            end
            default:
            begin
                cw.aluop = alu_pass;
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

/* logic/lc3b_types.sv */
`default_nettype none
`include "lc3b_cfg.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0]  lc3b_reg;
    typedef logic [2:0]              lc3b_nzp;

    // isa encodings, ldb/stb/jsr/rti are not handled here
    typedef enum logic [`LC3B_OPC_W-1:0]
    {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0]
    {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef struct packed
    {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       load_cc;
        logic       load_regfile;
        logic       branch_stall;
        logic       mem_read;
        logic       mem_write;
        logic       sr1_needed;
        logic       sr2_needed;
        logic       lshf_enable;
        logic [1:0] sr2mux_sel;     // sr2, imm5, imm4
        logic       addr1mux_sel;   // npc or sr1
        logic [1:0] addr2mux_sel;   // zero, off6, off9, off11
        logic       memaddrmux_sel; // adder or trap vector
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

/* include/lc3b_cfg.svh */
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// data and address width
`define LC3B_WORD_W 16

// eight architectural registers
`define LC3B_REG_W 3

// opcode field, top bits of the instruction word
`define LC3B_OPC_W 4

`endif
